// File: sources.f
+incdir+testbench
hw/gcore_pkg.sv
hw/gcore_decoder.sv
hw/gcore_fetch_decode.sv
hw/gcore_exec.sv
hw/gcore_mem.sv
hw/gcore_regfile.sv
hw/gcore_top.sv
testbench/tb_gcore.sv

// File: testbench/tb_gcore_prog.svh
logic [gcore_pkg::inst_w-1:0]  prog [$]; // indexed by word address
logic [gcore_pkg::daddr_w-1:0] exp_addr [$];
logic [gcore_pkg::data_w-1:0]  exp_data [$];
gcore_pkg::funct_e             fn_list [$];
gcore_pkg::opcode_e            op_list [$]; // immediate group only
bit                            drop_valid [1024];

function automatic logic [31:0] r_type(gcore_pkg::funct_e fn, int rd, int rs, int rt, int sh);
    return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic logic [31:0] i_type(gcore_pkg::opcode_e op, int rt, int rs, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic logic [31:0] random_inst();
    int pick;
    int rd;
    int rs;
    int rt;
    int imm;
    int sel;
    pick = $urandom_range(9);
    rd   = $urandom_range(7); // small window keeps dependences frequent, r0 included
    rs   = $urandom_range(7);
    rt   = $urandom_range(7);
    imm  = $urandom_range(16'hffff);
    if (pick < 2)
        return i_type(gcore_pkg::op_sw, rt, rs, imm);
    if (pick < 6) begin
        sel = $urandom_range(fn_list.size() - 1);
        return r_type(fn_list[sel], rd, rs, rt, imm % 32);
    end
    sel = $urandom_range(op_list.size() - 1);
    return i_type(op_list[sel], rd, rs, imm);
endfunction

// value one instruction produces from its rs and rt values, the address for sw
function automatic logic [31:0] ref_result(logic [31:0] w, logic [31:0] a, logic [31:0] b);
    logic [31:0] se;
    logic [31:0] ze;
    logic [4:0]  sh;
    se = {{16{w[15]}}, w[15:0]};
    ze = {16'd0, w[15:0]};
    sh = w[10:6];
    case (w[31:26])
        gcore_pkg::op_special: begin
            case (w[5:0])
                gcore_pkg::fn_sll:  return b << sh;
                gcore_pkg::fn_srl:  return b >> sh;
                gcore_pkg::fn_sra:  return $signed(b) >>> sh;
                gcore_pkg::fn_sllv: return a << b[4:0]; // rs moved by rt in this core
                gcore_pkg::fn_srlv: return a >> b[4:0];
                gcore_pkg::fn_srav: return $signed(a) >>> b[4:0];
                gcore_pkg::fn_add, gcore_pkg::fn_addu: return a + b;
                gcore_pkg::fn_sub, gcore_pkg::fn_subu: return a - b;
                gcore_pkg::fn_and:  return a & b;
                gcore_pkg::fn_or:   return a | b;
                gcore_pkg::fn_xor:  return a ^ b;
                gcore_pkg::fn_nor:  return ~(a | b);
                gcore_pkg::fn_slt:  return {31'd0, $signed(a) < $signed(b)};
                gcore_pkg::fn_sltu: return {31'd0, a < b};
                default:            return '0;
            endcase
        end
        gcore_pkg::op_addi:  return a + se;
        gcore_pkg::op_addiu: return a + ze; // zero-extended here
        gcore_pkg::op_slti:  return {31'd0, $signed(a) < $signed(se)};
        gcore_pkg::op_sltiu: return {31'd0, a < ze};
        gcore_pkg::op_andi:  return a & ze;
        gcore_pkg::op_ori:   return a | ze;
        gcore_pkg::op_xori:  return a ^ ze;
        gcore_pkg::op_lui:   return {w[15:0], 16'd0};
        gcore_pkg::op_sw:    return a + se;
        default:             return '0;
    endcase
endfunction

// runs the program in order on a model register file
function automatic void interpret_program();
    logic [31:0] regs [32];
    logic [31:0] y;
    logic [4:0]  dst;
    foreach (regs[k]) regs[k] = '0;
    foreach (prog[k]) begin
        y   = ref_result(prog[k], regs[prog[k][25:21]], regs[prog[k][20:16]]);
        dst = (prog[k][31:26] == gcore_pkg::op_special) ? prog[k][15:11] : prog[k][20:16];
        if (prog[k][31:26] == gcore_pkg::op_sw) begin
            exp_addr.push_back(y[gcore_pkg::daddr_w-1:0]);
            exp_data.push_back(regs[prog[k][20:16]]);
        end else if (dst != 0) begin
            regs[dst] = y; // r0 stays zero
        end
    end
endfunction

function automatic void build_program();
    gcore_pkg::funct_e  fn;
    gcore_pkg::opcode_e op;
    fn = fn.first();
    repeat (fn.num()) begin
        fn_list.push_back(fn);
        fn = fn.next();
    end
    op = op.first();
    repeat (op.num()) begin
        if (op != gcore_pkg::op_special && op != gcore_pkg::op_sw)
            op_list.push_back(op);
        op = op.next();
    end
    prog.push_back(i_type(gcore_pkg::op_lui, 1, 0, 'h1234));
    prog.push_back(i_type(gcore_pkg::op_ori, 1, 1, 'h5678)); // back to back, bubble
    prog.push_back(i_type(gcore_pkg::op_lui, 2, 0, 'hfedc));
    prog.push_back(i_type(gcore_pkg::op_ori, 2, 2, 'h0013));
    prog.push_back(i_type(gcore_pkg::op_addi, 3, 0, 'hff85)); // negative
    prog.push_back(i_type(gcore_pkg::op_xori, 4, 0, 'h8001));
    foreach (fn_list[k]) begin
        prog.push_back(r_type(fn_list[k], 10, 1, 2, 7));
        prog.push_back(i_type(gcore_pkg::op_sw, 10, 0, k * 4)); // data from previous result
        prog.push_back(r_type(fn_list[k], 11, 3, 4, 13));
        prog.push_back(i_type(gcore_pkg::op_sw, 11, 0, 'h80 + k * 4));
    end
    foreach (op_list[k]) begin
        prog.push_back(i_type(op_list[k], 12, 3, 'h8765));
        prog.push_back(i_type(op_list[k], 13, 1, 'h00f3));
        prog.push_back(i_type(gcore_pkg::op_sw, 12, 0, 'h100 + k * 8)); // distance two
        prog.push_back(i_type(gcore_pkg::op_sw, 13, 0, 'h104 + k * 8));
    end
    prog.push_back(r_type(gcore_pkg::fn_add, 14, 1, 2, 0));
    prog.push_back(r_type(gcore_pkg::fn_xor, 15, 3, 4, 0));
    prog.push_back(r_type(gcore_pkg::fn_sub, 16, 14, 15, 0)); // r15 forwarded after the bubble
    prog.push_back(i_type(gcore_pkg::op_sw, 16, 14, 'hfff0));
    repeat (200) prog.push_back(random_inst());
    foreach (drop_valid[k]) drop_valid[k] = ($urandom_range(3) == 0);
endfunction

// File: testbench/tb_gcore.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gcore;

    logic                          clk;
    logic                          rst;
    logic [gcore_pkg::inst_w-1:0]  i_inst_data;
    logic                          i_inst_valid;
    logic [gcore_pkg::addr_w-1:0]  o_inst_addr;
    logic [gcore_pkg::daddr_w-1:0] o_data_addr;
    logic [gcore_pkg::data_w-1:0]  o_data_out;
    logic                          o_data_we;

    `include "tb_gcore_prog.svh"

    gcore_top i_gcore_top (
        .clk(clk), .rst(rst), .i_inst_data(i_inst_data), .i_inst_valid(i_inst_valid),
        .o_inst_addr(o_inst_addr), .o_data_addr(o_data_addr),
        .o_data_out(o_data_out), .o_data_we(o_data_we)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic wait_for_store(input int n);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!o_data_we) begin
            cycles++;
            assert (cycles < 2000) else fail_run($sformatf("timed out waiting for store %0d", n));
            @(negedge clk);
        end
    endtask

    // instruction memory model with random gaps in valid
    initial begin
        int          cyc;
        int unsigned idx;
        cyc          = 0;
        i_inst_data  = gcore_pkg::noop;
        i_inst_valid = 1'b0;
        forever begin
            @(negedge clk);
            idx          = o_inst_addr >> 2;
            i_inst_valid = !drop_valid[cyc % 1024];
            i_inst_data  = (idx < prog.size()) ? prog[idx] : gcore_pkg::noop;
            cyc++;
        end
    end

    initial begin
        rst = 1'b1;
        void'($urandom(32'hfbc5));
        build_program();
        interpret_program();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (o_data_we == 1'b0) else
            fail_run($sformatf("ERROR at time %0t: store strobe high right after reset", $time));
        for (int n = 0; n < exp_addr.size(); n++) begin
            wait_for_store(n);
            assert (o_data_addr == exp_addr[n] && o_data_out == exp_data[n]) else
                fail_run($sformatf("ERROR at time %0t: store %0d wrote %h to %h, expected %h to %h",
                         $time, n, o_data_out, o_data_addr, exp_data[n], exp_addr[n]));
        end
        repeat (40) begin // nothing may follow the last store
            @(negedge clk);
            assert (!o_data_we) else
                fail_run($sformatf("ERROR at time %0t: extra store to %h", $time, o_data_addr));
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/gcore_top.sv
`timescale 1ns/1ps
`default_nettype none

module gcore_top (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  [gcore_pkg::inst_w-1:0]  i_inst_data,
    input  wire                           i_inst_valid,
    output logic [gcore_pkg::addr_w-1:0]  o_inst_addr,
    output logic [gcore_pkg::daddr_w-1:0] o_data_addr,
    output logic [gcore_pkg::data_w-1:0]  o_data_out,
    output logic                          o_data_we
);

    logic [gcore_pkg::inst_w-1:0]     fd_inst;
    logic                             fd_reg_we;
    gcore_pkg::alu_op_e               fd_alu_op;
    gcore_pkg::a_sel_e                fd_a_sel;
    gcore_pkg::b_sel_e                fd_b_sel;
    logic                             fd_sign_ext;
    gcore_pkg::res_sel_e              fd_res_sel;
    logic                             fd_mem_w;
    logic                             fd_fwd_a;
    logic                             fd_fwd_b;
    logic                             fd_fwd_st;
    logic [gcore_pkg::reg_addr_w-1:0] ex_rs_addr;
    logic [gcore_pkg::reg_addr_w-1:0] ex_rt_addr;
    logic [gcore_pkg::data_w-1:0]     rf_rs_data;
    logic [gcore_pkg::data_w-1:0]     rf_rt_data;
    logic [gcore_pkg::inst_w-1:0]     ex_inst;
    logic                             ex_reg_we;
    gcore_pkg::res_sel_e              ex_res_sel;
    logic                             ex_mem_w;
    logic [gcore_pkg::data_w-1:0]     ex_result;
    logic [gcore_pkg::data_w-1:0]     ex_rt_data;
    logic [gcore_pkg::inst_w-1:0]     mem_inst;
    logic                             mem_reg_we;
    logic [gcore_pkg::data_w-1:0]     mem_result;
    logic [gcore_pkg::reg_addr_w-1:0] wb_addr;
    logic                             wb_we;

    // write-back: rd for R-type, rt for the immediate group
    assign wb_addr = (mem_inst[gcore_pkg::op_msb:gcore_pkg::op_lsb] == gcore_pkg::op_special) ?
                     mem_inst[gcore_pkg::rd_lsb +: gcore_pkg::reg_addr_w] :
                     mem_inst[gcore_pkg::rt_lsb +: gcore_pkg::reg_addr_w];
    assign wb_we   = mem_reg_we && (wb_addr != '0);

    gcore_fetch_decode i_fetch_decode (
        .clk(clk), .rst(rst),
        .i_inst_data(i_inst_data), .i_inst_valid(i_inst_valid), .o_inst_addr(o_inst_addr),
        .o_inst(fd_inst), .o_reg_we(fd_reg_we), .o_alu_op(fd_alu_op),
        .o_a_sel(fd_a_sel), .o_b_sel(fd_b_sel), .o_sign_ext(fd_sign_ext),
        .o_res_sel(fd_res_sel), .o_mem_w(fd_mem_w),
        .o_fwd_a(fd_fwd_a), .o_fwd_b(fd_fwd_b), .o_fwd_st(fd_fwd_st)
    );

    gcore_exec i_exec (
        .clk(clk), .rst(rst),
        .i_inst(fd_inst), .i_reg_we(fd_reg_we), .i_alu_op(fd_alu_op),
        .i_a_sel(fd_a_sel), .i_b_sel(fd_b_sel), .i_sign_ext(fd_sign_ext),
        .i_res_sel(fd_res_sel), .i_mem_w(fd_mem_w),
        .i_fwd_a(fd_fwd_a), .i_fwd_b(fd_fwd_b), .i_fwd_st(fd_fwd_st),
        .i_rs_data(rf_rs_data), .i_rt_data(rf_rt_data), .i_mem_result(mem_result),
        .o_rs_addr(ex_rs_addr), .o_rt_addr(ex_rt_addr), .o_inst(ex_inst),
        .o_reg_we(ex_reg_we), .o_res_sel(ex_res_sel), .o_mem_w(ex_mem_w),
        .o_exec_result(ex_result), .o_rt_data(ex_rt_data)
    );

    gcore_mem i_mem (
        .clk(clk), .rst(rst),
        .i_inst(ex_inst), .i_reg_we(ex_reg_we), .i_res_sel(ex_res_sel), .i_mem_w(ex_mem_w),
        .i_exec_result(ex_result), .i_rt_data(ex_rt_data),
        .o_data_addr(o_data_addr), .o_data_out(o_data_out), .o_data_we(o_data_we),
        .o_inst(mem_inst), .o_reg_we(mem_reg_we), .o_mem_result(mem_result)
    );

    gcore_regfile i_regfile (
        .clk(clk), .rst(rst),
        .i_rs_addr(ex_rs_addr), .i_rt_addr(ex_rt_addr),
        .i_wr_addr(wb_addr), .i_wr_data(mem_result), .i_wr_en(wb_we),
        .o_rs_data(rf_rs_data), .o_rt_data(rf_rt_data)
    );

endmodule

`default_nettype wire

// File: hw/gcore_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module gcore_regfile (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [gcore_pkg::reg_addr_w-1:0] i_rs_addr,
    input  wire  [gcore_pkg::reg_addr_w-1:0] i_rt_addr,
    input  wire  [gcore_pkg::reg_addr_w-1:0] i_wr_addr,
    input  wire  [gcore_pkg::data_w-1:0]     i_wr_data,
    input  wire                              i_wr_en,
    output logic [gcore_pkg::data_w-1:0]     o_rs_data,
    output logic [gcore_pkg::data_w-1:0]     o_rt_data
);

    logic [gcore_pkg::data_w-1:0] rf [1:31]; // no storage behind r0

    assign o_rs_data = (i_rs_addr == '0) ? '0 : rf[i_rs_addr];
    assign o_rt_data = (i_rt_addr == '0) ? '0 : rf[i_rt_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (i_wr_en) begin
            rf[i_wr_addr] <= i_wr_data;
        end
    end

    // write-back in the top level drops r0 writes before they get here
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst) i_wr_en |-> i_wr_addr != '0);

endmodule

`default_nettype wire

// File: hw/gcore_mem.sv
`timescale 1ns/1ps
`default_nettype none

module gcore_mem (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  [gcore_pkg::inst_w-1:0]  i_inst,
    input  wire                           i_reg_we,
    input  wire  gcore_pkg::res_sel_e     i_res_sel,
    input  wire                           i_mem_w,
    input  wire  [gcore_pkg::data_w-1:0]  i_exec_result,
    input  wire  [gcore_pkg::data_w-1:0]  i_rt_data,
    output logic [gcore_pkg::daddr_w-1:0] o_data_addr,
    output logic [gcore_pkg::data_w-1:0]  o_data_out,
    output logic                          o_data_we,
    output logic [gcore_pkg::inst_w-1:0]  o_inst,
    output logic                          o_reg_we,
    output logic [gcore_pkg::data_w-1:0]  o_mem_result
);

    assign o_data_addr = i_exec_result[gcore_pkg::daddr_w-1:0];
    assign o_data_out  = i_rt_data;
    assign o_data_we   = i_mem_w; // execute register moves every edge, so one cycle per sw

    always_ff @(posedge clk) begin
        if (rst) begin
            o_reg_we <= 1'b0;
        end else begin
            o_reg_we <= i_reg_we;
        end
    end

    always_ff @(posedge clk) begin
        o_inst <= i_inst;
        if (i_res_sel == gcore_pkg::res_lui) begin
            o_mem_result <= {i_exec_result[gcore_pkg::data_w-gcore_pkg::imm_w-1:0],
                             {gcore_pkg::imm_w{1'b0}}};
        end else begin
            o_mem_result <= i_exec_result;
        end
    end

endmodule

`default_nettype wire

// File: hw/gcore_exec.sv
`timescale 1ns/1ps
`default_nettype none

module gcore_exec (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [gcore_pkg::inst_w-1:0]     i_inst,
    input  wire                              i_reg_we,
    input  wire  gcore_pkg::alu_op_e         i_alu_op,
    input  wire  gcore_pkg::a_sel_e          i_a_sel,
    input  wire  gcore_pkg::b_sel_e          i_b_sel,
    input  wire                              i_sign_ext,
    input  wire  gcore_pkg::res_sel_e        i_res_sel,
    input  wire                              i_mem_w,
    input  wire                              i_fwd_a,
    input  wire                              i_fwd_b,
    input  wire                              i_fwd_st,
    input  wire  [gcore_pkg::data_w-1:0]     i_rs_data,
    input  wire  [gcore_pkg::data_w-1:0]     i_rt_data,
    input  wire  [gcore_pkg::data_w-1:0]     i_mem_result,
    output logic [gcore_pkg::reg_addr_w-1:0] o_rs_addr,
    output logic [gcore_pkg::reg_addr_w-1:0] o_rt_addr,
    output logic [gcore_pkg::inst_w-1:0]     o_inst,
    output logic                             o_reg_we,
    output gcore_pkg::res_sel_e              o_res_sel,
    output logic                             o_mem_w,
    output logic [gcore_pkg::data_w-1:0]     o_exec_result,
    output logic [gcore_pkg::data_w-1:0]     o_rt_data
);

    logic [gcore_pkg::data_w-1:0] imm;
    logic [gcore_pkg::data_w-1:0] alu_a;
    logic [gcore_pkg::data_w-1:0] alu_b;
    logic [gcore_pkg::data_w-1:0] alu_y;
    logic [gcore_pkg::reg_addr_w-1:0] shamt;

    assign o_rs_addr = i_inst[gcore_pkg::rs_lsb +: gcore_pkg::reg_addr_w];
    assign o_rt_addr = i_inst[gcore_pkg::rt_lsb +: gcore_pkg::reg_addr_w];
    assign shamt     = i_inst[gcore_pkg::shamt_lsb +: gcore_pkg::reg_addr_w];
    assign imm = {{(gcore_pkg::data_w-gcore_pkg::imm_w){i_sign_ext & i_inst[gcore_pkg::imm_w-1]}},
                  i_inst[gcore_pkg::imm_w-1:0]};

    assign alu_a = i_fwd_a ? i_mem_result :
                   (i_a_sel == gcore_pkg::a_rs) ? i_rs_data :
                   (i_a_sel == gcore_pkg::a_rt) ? i_rt_data : '0;
    assign alu_b = i_fwd_b ? i_mem_result :
                   (i_b_sel == gcore_pkg::b_rt)  ? i_rt_data :
                   (i_b_sel == gcore_pkg::b_imm) ? imm :
                   {{(gcore_pkg::data_w-gcore_pkg::reg_addr_w){1'b0}}, shamt};

    always_comb begin
        case (i_alu_op)
            gcore_pkg::alu_add:  alu_y = alu_a + alu_b;
            gcore_pkg::alu_sub:  alu_y = alu_a - alu_b;
            gcore_pkg::alu_and:  alu_y = alu_a & alu_b;
            gcore_pkg::alu_or:   alu_y = alu_a | alu_b;
            gcore_pkg::alu_xor:  alu_y = alu_a ^ alu_b;
            gcore_pkg::alu_nor:  alu_y = ~(alu_a | alu_b);
            gcore_pkg::alu_sll:  alu_y = alu_a << alu_b[gcore_pkg::reg_addr_w-1:0];
            gcore_pkg::alu_srl:  alu_y = alu_a >> alu_b[gcore_pkg::reg_addr_w-1:0];
            gcore_pkg::alu_sra:  alu_y = $signed(alu_a) >>> alu_b[gcore_pkg::reg_addr_w-1:0];
            gcore_pkg::alu_slt:  alu_y = {31'd0, $signed(alu_a) < $signed(alu_b)};
            gcore_pkg::alu_sltu: alu_y = {31'd0, alu_a < alu_b};
            default:             alu_y = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_reg_we  <= 1'b0;
            o_mem_w   <= 1'b0;
            o_res_sel <= gcore_pkg::res_alu;
        end else begin
            o_reg_we  <= i_reg_we;
            o_mem_w   <= i_mem_w;
            o_res_sel <= i_res_sel;
        end
    end

    always_ff @(posedge clk) begin
        o_inst        <= i_inst;
        o_exec_result <= alu_y;
        o_rt_data     <= i_fwd_st ? i_mem_result : i_rt_data; // store data
    end

    // instruction register comes out of reset as a no-op, so the op is defined from then on
    a_alu_op_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(i_alu_op));

endmodule

`default_nettype wire

// File: hw/gcore_fetch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module gcore_fetch_decode (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [gcore_pkg::inst_w-1:0] i_inst_data,
    input  wire                          i_inst_valid,
    output logic [gcore_pkg::addr_w-1:0] o_inst_addr,
    output logic [gcore_pkg::inst_w-1:0] o_inst,
    output logic                         o_reg_we,
    output gcore_pkg::alu_op_e           o_alu_op,
    output gcore_pkg::a_sel_e            o_a_sel,
    output gcore_pkg::b_sel_e            o_b_sel,
    output logic                         o_sign_ext,
    output gcore_pkg::res_sel_e          o_res_sel,
    output logic                         o_mem_w,
    output logic                         o_fwd_a,
    output logic                         o_fwd_b,
    output logic                         o_fwd_st
);

    gcore_pkg::dst_sel_e                 dst_sel;
    logic                                uses_rs;
    logic                                uses_rt;
    logic                                n_uses_rs;
    logic                                n_uses_rt;
    logic [gcore_pkg::reg_addr_w-1:0]    rs;
    logic [gcore_pkg::reg_addr_w-1:0]    rt;
    logic [gcore_pkg::reg_addr_w-1:0]    n_rs;
    logic [gcore_pkg::reg_addr_w-1:0]    n_rt;
    logic [gcore_pkg::reg_addr_w-1:0]    dst_ir; // 0 when nothing is written
    logic [gcore_pkg::reg_addr_w-1:0]    dst_ex;
    logic [gcore_pkg::reg_addr_w-1:0]    dst_mem;
    logic                                bubble;

    gcore_decoder i_dec_cur (
        .i_inst     (o_inst),
        .o_reg_we   (o_reg_we),
        .o_dst_sel  (dst_sel),
        .o_alu_op   (o_alu_op),
        .o_a_sel    (o_a_sel),
        .o_b_sel    (o_b_sel),
        .o_sign_ext (o_sign_ext),
        .o_res_sel  (o_res_sel),
        .o_mem_w    (o_mem_w),
        .o_uses_rs  (uses_rs),
        .o_uses_rt  (uses_rt)
    );

    gcore_decoder i_dec_next ( // only the operand-use flags matter here
        .i_inst     (i_inst_data),
        .o_reg_we   (),
        .o_dst_sel  (),
        .o_alu_op   (),
        .o_a_sel    (),
        .o_b_sel    (),
        .o_sign_ext (),
        .o_res_sel  (),
        .o_mem_w    (),
        .o_uses_rs  (n_uses_rs),
        .o_uses_rt  (n_uses_rt)
    );

    assign rs     = o_inst[gcore_pkg::rs_lsb +: gcore_pkg::reg_addr_w];
    assign rt     = o_inst[gcore_pkg::rt_lsb +: gcore_pkg::reg_addr_w];
    assign n_rs   = i_inst_data[gcore_pkg::rs_lsb +: gcore_pkg::reg_addr_w];
    assign n_rt   = i_inst_data[gcore_pkg::rt_lsb +: gcore_pkg::reg_addr_w];
    assign dst_ir = !o_reg_we ? '0 :
                    (dst_sel == gcore_pkg::dst_rd) ? o_inst[gcore_pkg::rd_lsb +: 5] : rt;

    assign bubble = !i_inst_valid
                  || (n_uses_rs && n_rs != '0 && n_rs == dst_ir)  // load-use style interlock
                  || (n_uses_rt && n_rt != '0 && n_rt == dst_ir);

    // dst_mem names the register held in the memory-stage result
    assign o_fwd_a  = (o_a_sel == gcore_pkg::a_rs) ? (uses_rs && rs != '0 && rs == dst_mem) :
                      (o_a_sel == gcore_pkg::a_rt) && rt != '0 && rt == dst_mem;
    assign o_fwd_b  = (o_b_sel == gcore_pkg::b_rt) && rt != '0 && rt == dst_mem;
    assign o_fwd_st = uses_rt && rt != '0 && rt == dst_mem;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_inst_addr <= '0;
            o_inst      <= gcore_pkg::noop;
            dst_ex      <= '0;
            dst_mem     <= '0;
        end else begin
            dst_ex  <= dst_ir;
            dst_mem <= dst_ex;
            if (bubble) begin
                o_inst <= gcore_pkg::noop; // pc holds
            end else begin
                o_inst      <= i_inst_data;
                o_inst_addr <= o_inst_addr + gcore_pkg::addr_w'(4);
            end
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        o_inst_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: hw/gcore_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module gcore_decoder (
    input  wire  [gcore_pkg::inst_w-1:0] i_inst,
    output logic                         o_reg_we,
    output gcore_pkg::dst_sel_e          o_dst_sel,
    output gcore_pkg::alu_op_e           o_alu_op,
    output gcore_pkg::a_sel_e            o_a_sel,
    output gcore_pkg::b_sel_e            o_b_sel,
    output logic                         o_sign_ext,
    output gcore_pkg::res_sel_e          o_res_sel,
    output logic                         o_mem_w,
    output logic                         o_uses_rs,
    output logic                         o_uses_rt
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = i_inst[gcore_pkg::op_msb:gcore_pkg::op_lsb];
    assign funct  = i_inst[gcore_pkg::shamt_lsb-1:0];

    always_comb begin
        o_reg_we   = 1'b0;
        o_dst_sel  = gcore_pkg::dst_rt;
        o_alu_op   = gcore_pkg::alu_add;
        o_a_sel    = gcore_pkg::a_rs;
        o_b_sel    = gcore_pkg::b_imm;
        o_sign_ext = 1'b0;
        o_res_sel  = gcore_pkg::res_alu;
        o_mem_w    = 1'b0;
        o_uses_rs  = 1'b0;
        o_uses_rt  = 1'b0;
        case (gcore_pkg::opcode_e'(opcode))
            gcore_pkg::op_special: begin
                o_reg_we  = 1'b1;
                o_dst_sel = gcore_pkg::dst_rd;
                o_b_sel   = gcore_pkg::b_rt;
                o_uses_rs = 1'b1;
                o_uses_rt = 1'b1;
                case (gcore_pkg::funct_e'(funct))
                    gcore_pkg::fn_add, gcore_pkg::fn_addu: o_alu_op = gcore_pkg::alu_add;
                    gcore_pkg::fn_sub, gcore_pkg::fn_subu: o_alu_op = gcore_pkg::alu_sub;
                    gcore_pkg::fn_and:  o_alu_op = gcore_pkg::alu_and;
                    gcore_pkg::fn_or:   o_alu_op = gcore_pkg::alu_or;
                    gcore_pkg::fn_xor:  o_alu_op = gcore_pkg::alu_xor;
                    gcore_pkg::fn_nor:  o_alu_op = gcore_pkg::alu_nor;
                    gcore_pkg::fn_slt:  o_alu_op = gcore_pkg::alu_slt;
                    gcore_pkg::fn_sltu: o_alu_op = gcore_pkg::alu_sltu;
                    gcore_pkg::fn_sll, gcore_pkg::fn_sllv: o_alu_op = gcore_pkg::alu_sll;
                    gcore_pkg::fn_srl, gcore_pkg::fn_srlv: o_alu_op = gcore_pkg::alu_srl;
                    gcore_pkg::fn_sra, gcore_pkg::fn_srav: o_alu_op = gcore_pkg::alu_sra;
                    default: begin
                        o_reg_we  = 1'b0;
                        o_uses_rs = 1'b0;
                        o_uses_rt = 1'b0;
                    end
                endcase
                // variable shifts move rs by rt[4:0], fixed shifts move rt by shamt
                if (funct inside {gcore_pkg::fn_sll, gcore_pkg::fn_srl, gcore_pkg::fn_sra}) begin
                    o_a_sel   = gcore_pkg::a_rt;
                    o_b_sel   = gcore_pkg::b_shamt;
                    o_uses_rs = 1'b0;
                end
            end
            gcore_pkg::op_addi: begin
                o_sign_ext = 1'b1;
            end
            gcore_pkg::op_andi:  o_alu_op = gcore_pkg::alu_and;
            gcore_pkg::op_ori:   o_alu_op = gcore_pkg::alu_or;
            gcore_pkg::op_xori:  o_alu_op = gcore_pkg::alu_xor;
            gcore_pkg::op_sltiu: o_alu_op = gcore_pkg::alu_sltu; // unsigned compare, zero-ext imm
            gcore_pkg::op_slti: begin
                o_alu_op   = gcore_pkg::alu_slt;
                o_sign_ext = 1'b1;
            end
            gcore_pkg::op_lui: begin
                o_a_sel   = gcore_pkg::a_zero; // 0 | imm, shifted up in memory stage
                o_alu_op  = gcore_pkg::alu_or;
                o_res_sel = gcore_pkg::res_lui;
            end
            gcore_pkg::op_sw: begin
                o_mem_w    = 1'b1;
                o_sign_ext = 1'b1;
                o_uses_rs  = 1'b1;
                o_uses_rt  = 1'b1;
            end
            default: o_mem_w = 1'b0; // addiu lands here too, plain add on zero-ext imm
        endcase
        if (opcode[5:3] == 3'b001) begin // the whole 001xxx group writes rt
            o_reg_we  = 1'b1;
            o_uses_rs = (opcode != gcore_pkg::op_lui);
        end
    end

endmodule

`default_nettype wire

// File: hw/gcore_pkg.sv
`default_nettype none

package gcore_pkg;

    localparam int inst_w     = 32;
    localparam int addr_w     = 32;
    localparam int data_w     = 32;
    localparam int daddr_w    = 20;
    localparam int reg_addr_w = 5;

    localparam logic [inst_w-1:0] noop = '0; // sll r0, r0, 0

    localparam int op_msb    = 31;
    localparam int op_lsb    = 26;
    localparam int rs_lsb    = 21;
    localparam int rt_lsb    = 16;
    localparam int rd_lsb    = 11;
    localparam int shamt_lsb = 6; // funct sits below shamt
    localparam int imm_w     = 16;

    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_addi    = 6'b001000,
        op_addiu   = 6'b001001,
        op_slti    = 6'b001010,
        op_sltiu   = 6'b001011,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_xori    = 6'b001110,
        op_lui     = 6'b001111,
        op_sw      = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll  = 6'b000000,
        fn_srl  = 6'b000010,
        fn_sra  = 6'b000011,
        fn_sllv = 6'b000100,
        fn_srlv = 6'b000110,
        fn_srav = 6'b000111,
        fn_add  = 6'b100000,
        fn_addu = 6'b100001,
        fn_sub  = 6'b100010,
        fn_subu = 6'b100011,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_xor  = 6'b100110,
        fn_nor  = 6'b100111,
        fn_slt  = 6'b101010,
        fn_sltu = 6'b101011
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_slt, alu_or, alu_xor,
        alu_nor, alu_sll, alu_srl, alu_sra, alu_sltu
    } alu_op_e;

    typedef enum logic [1:0] {a_rs, a_rt, a_zero} a_sel_e;
    typedef enum logic [1:0] {b_rt, b_imm, b_shamt} b_sel_e;
    typedef enum logic {res_alu, res_lui} res_sel_e;
    typedef enum logic {dst_rd, dst_rt} dst_sel_e;

endpackage

`default_nettype wire
